/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = link_rx_tb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^Result: PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hdl/fifo.sv */
/* cyclic FIFO of 2^adr_width flits with registered full and empty flags.
   a pop on empty is dropped, a push on full is only legal together with a pop */
`default_nettype none

module fifo
   import link_pkg::*;
   #(
      parameter int adr_width = 3
   )
   (
      input  logic  clk,
      input  logic  reset,
      input  logic  push,
      input  flit_t push_flit,
      input  logic  pop,
      output flit_t head,
      output logic  empty,
      output logic  full
   );

   localparam int depth = 1 << adr_width;

   flit_t mem [depth];   // payload only, no reset

   logic [adr_width-1:0] w_ptr;
   logic [adr_width-1:0] w_ptr_next;
   logic [adr_width-1:0] r_ptr;
   logic [adr_width-1:0] r_ptr_next;
   logic full_reg;
   logic full_next;
   logic empty_reg;
   logic empty_next;
   logic do_push;
   logic do_pop;

   assign do_pop  = pop & ~empty_reg;
   assign do_push = push & (~full_reg | do_pop);   // slot freed by the same-cycle pop

   assign head  = mem[r_ptr];   // read combinationally at the head
   assign empty = empty_reg;
   assign full  = full_reg;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[w_ptr] <= push_flit;
   end

   // pointers and flags
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         w_ptr     <= '0;
         r_ptr     <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
      end
      else
      begin
         w_ptr     <= w_ptr_next;
         r_ptr     <= r_ptr_next;
         full_reg  <= full_next;
         empty_reg <= empty_next;
      end
   end

   always_comb
   begin
      w_ptr_next = w_ptr;
      r_ptr_next = r_ptr;
      full_next  = full_reg;
      empty_next = empty_reg;
      case ({do_push, do_pop})
         2'b10:   // write only
         begin
            w_ptr_next = w_ptr + 1'b1;
            empty_next = 1'b0;
            full_next  = (w_ptr_next == r_ptr);   // writer caught up with reader
         end
         2'b01:   // read only
         begin
            r_ptr_next = r_ptr + 1'b1;
            full_next  = 1'b0;
            empty_next = (r_ptr_next == w_ptr);
         end
         2'b11:   // both move, occupancy unchanged
         begin
            w_ptr_next = w_ptr + 1'b1;
            r_ptr_next = r_ptr + 1'b1;
         end
         default:
         begin
            w_ptr_next = w_ptr;
            r_ptr_next = r_ptr;
         end
      endcase
   end

   // the upstream sender holds only 2^adr_width credits, so a full
   // FIFO means it has none left
   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      full_reg |-> !push)
      else $error("fifo: push while full");

   a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(full_reg && empty_reg))
      else $error("fifo: full and empty together");

endmodule

`default_nettype wire

/* hdl/frame_summer.sv */
/* sums the data words of each frame from the FIFO head, end flit included.
   an end flit waits at the head until a downstream credit is held */
`default_nettype none

module frame_summer
   import link_pkg::*;
   #(
      parameter int adr_width = 3
   )
   (
      input  logic          clk,
      input  logic          reset,
      input  flit_t         head,
      input  logic          empty,
      output logic          pop,
      output logic          credit_return,
      input  logic          out_credit,
      output logic          result_valid,
      output frame_result_t result
   );

   // room for more grants than the FIFO can hold results for
   localparam int credit_width = adr_width + 2;
   localparam logic [credit_width-1:0] credit_max = '1;

   logic [credit_width-1:0] credits;    // downstream credits held
   logic [data_width-1:0]   sum;        // running sum of the open frame
   logic [count_width-1:0]  count;      // flits of the open frame
   logic [count_width-1:0]  count_inc;
   logic                    has_credit;
   logic                    head_end;
   logic                    spend;

   assign has_credit = (credits != '0);
   assign head_end   = (head.op == op_end);

   // data flits always go, an end flit needs a credit
   assign pop   = ~empty & (~head_end | has_credit);
   assign spend = pop & head_end;

   assign count_inc = (count == '1) ? count : count + 1'b1;   // saturate at 255

   // downstream credit counter
   always_ff @(posedge clk)
   begin
      if (reset)
         credits <= '0;
      else
      begin
         case ({out_credit, spend})
            2'b10:
            begin
               if (credits != credit_max)   // hold at max
                  credits <= credits + 1'b1;
            end
            2'b01:
               credits <= credits - 1'b1;
            default:
               credits <= credits;   // grant and spend cancel
         endcase
      end
   end

   // accumulators and output strobes
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         credit_return <= 1'b0;
         result_valid  <= 1'b0;
         sum           <= '0;
         count         <= '0;
      end
      else
      begin
         credit_return <= pop;     // one upstream credit per popped flit
         result_valid  <= spend;
         if (pop)
         begin
            if (head_end)
            begin
               sum   <= '0;   // next frame starts clean
               count <= '0;
            end
            else
            begin
               sum   <= sum + head.data;
               count <= count_inc;
            end
         end
      end
   end

   // completed frame, qualified by result_valid
   always_ff @(posedge clk)
   begin
      if (spend)
      begin
         result.sum   <= sum + head.data;
         result.count <= count_inc;
      end
   end

   a_result_needs_credit: assert property (@(posedge clk) disable iff (reset)
      result_valid |-> $past(has_credit))
      else $error("frame_summer: result sent without a credit");

   a_credit_no_wrap_up: assert property (@(posedge clk) disable iff (reset)
      (credits == credit_max) |=> (credits != '0))
      else $error("frame_summer: credit counter wrapped up");

   a_credit_no_wrap_down: assert property (@(posedge clk) disable iff (reset)
      (credits == '0) |=> (credits != credit_max))
      else $error("frame_summer: credit counter wrapped down");

endmodule

`default_nettype wire

/* hdl/link_pkg.sv */
/* flit and result types for the receive side of the word link.
   data width is fixed at 16 bits and the frame count saturates at 255 */
`default_nettype none

package link_pkg;

   localparam int data_width = 16;   // data word width
   localparam int count_width = 8;   // flits per frame, saturating

   // flit opcodes
   typedef enum logic [0:0]
   {
      op_data = 1'b0,
      op_end  = 1'b1   // last flit of a frame, its data word is summed too
   } flit_op_t;

   // one word on the upstream link, 17 bits
   typedef struct packed
   {
      flit_op_t              op;
      logic [data_width-1:0] data;
   } flit_t;

   // one completed frame for the downstream side, 24 bits
   typedef struct packed
   {
      logic [data_width-1:0]  sum;     // modulo 2^16
      logic [count_width-1:0] count;   // end flit included
   } frame_result_t;

endpackage

`default_nettype wire

/* hdl/link_rx_top.sv */
/* receive side of the word link, FIFO plus frame summer.
   upstream starts with 2^adr_width credits, downstream with none */
`default_nettype none

module link_rx_top
   import link_pkg::*;
   #(
      parameter int adr_width = 3   // depth 8, valid from 1 to 8
   )
   (
      input  logic          clk,
      input  logic          reset,
      input  logic          in_valid,
      input  flit_t         in_flit,
      output logic          credit_return,
      input  logic          out_credit,
      output logic          result_valid,
      output frame_result_t result
   );

   flit_t head;    // FIFO head, read combinationally
   logic  empty;
   logic  pop;

   // full is not needed here, the credit loop keeps writes in bounds
   fifo #(
      .adr_width (adr_width)
   ) u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (in_valid),
      .push_flit (in_flit),
      .pop       (pop),
      .head      (head),
      .empty     (empty),
      .full      ()
   );

   frame_summer #(
      .adr_width (adr_width)
   ) u_summer (
      .clk           (clk),
      .reset         (reset),
      .head          (head),
      .empty         (empty),
      .pop           (pop),
      .credit_return (credit_return),
      .out_credit    (out_credit),
      .result_valid  (result_valid),
      .result        (result)
   );

endmodule

`default_nettype wire

/* src.f */
hdl/link_pkg.sv
hdl/fifo.sv
hdl/frame_summer.sv
hdl/link_rx_top.sv
test/link_rx_monitor.sv
test/link_rx_tb.sv

/* test/link_rx_monitor.sv */
/* checks results, credit rules and the single stall phase of link_rx_top.
   expected sums come from test/link_rx_patterns.txt, read from the project root */
`default_nettype none

module link_rx_monitor
   import link_pkg::*;
   #(
      parameter int adr_width = 3
   )
   (
      input  logic          clk,
      input  logic          reset,
      input  logic          in_valid,
      input  logic          credit_return,
      input  logic          out_credit,
      input  logic          result_valid,
      input  frame_result_t result,
      input  logic          stalled,
      input  logic          run_done,
      output int            value_errors,
      output int            protocol_errors,
      output bit            final_done
   );

   timeunit 1ns;
   timeprecision 100ps;

   localparam int depth = 1 << adr_width;

   frame_result_t exp_res [$];
   int   n_flits = 0;
   bit   file_bad = 1'b0;
   int   pushes = 0;
   int   returns = 0;
   int   grants = 0;
   int   results = 0;
   int   stall_pushes = 0;
   bit   seen_flit = 1'b0;
   bit   stall_seen = 1'b0;
   logic stalled_q = 1'b0;

   // expected results frame by frame
   initial
   begin
      int            fd;
      logic [31:0]   op_v;
      logic [15:0]   data_v;
      int            gap_v;
      logic [15:0]   run_sum;
      int            run_count;
      frame_result_t r;
      run_sum = '0;
      run_count = 0;
      fd = $fopen("test/link_rx_patterns.txt", "r");
      if (fd == 0)
         file_bad = 1'b1;
      else
      begin
         while ($fscanf(fd, "%h %h %d", op_v, data_v, gap_v) == 3)
         begin
            n_flits++;
            run_sum = run_sum + data_v;   // wraps at 2^16
            run_count = (run_count < 255) ? run_count + 1 : 255;
            if (op_v == 1)
            begin
               r.sum   = run_sum;
               r.count = 8'(run_count);
               exp_res.push_back(r);
               run_sum = '0;
               run_count = 0;
            end
         end
         $fclose(fd);
      end
   end

   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (!seen_flit && (credit_return || result_valid))
         begin
            protocol_errors++;
            $display("an output strobe rose after reset before any flit was sent");
         end
         if (in_valid)
         begin
            if (pushes - returns >= depth)   // upstream credits would go negative
            begin
               protocol_errors++;
               $display("the sender pushed a flit with no upstream credit left");
            end
            pushes++;
            seen_flit = 1'b1;
         end
         if (credit_return)
         begin
            returns++;
            if (returns > pushes)
            begin
               protocol_errors++;
               $display("a credit came back for a flit that was never sent");
            end
         end
         if (out_credit)
            grants++;
         if (result_valid)
         begin
            results++;
            if (results > grants)
            begin
               protocol_errors++;
               $display("a result went out with no downstream credit granted");
            end
            if (results > exp_res.size())
            begin
               protocol_errors++;
               $display("a result came after the last frame of the pattern file");
            end
            else if (result !== exp_res[results-1])
            begin
               value_errors++;
               $display(
                  "Error frame_sums frame %0d: expected sum %h count %0d, actual sum %h count %0d",
                  results - 1, exp_res[results-1].sum, exp_res[results-1].count,
                  result.sum, result.count);
            end
         end
         if (stalled)
         begin
            stall_seen = 1'b1;
            if (in_valid)
               stall_pushes++;
            if (credit_return || result_valid)
            begin
               protocol_errors++;
               $display("the DUT returned a credit or a result while its head was stalled");
            end
         end
         if (stalled_q && !stalled && stall_pushes != depth - 1)
         begin
            value_errors++;
            $display("Error fifo_fill: expected %0d flits, actual %0d", depth - 1, stall_pushes);
         end
         stalled_q = stalled;
         if (run_done && !final_done)
         begin
            if (results != exp_res.size())
            begin
               value_errors++;
               $display("Error frame_sums result count: expected %0d, actual %0d",
                        exp_res.size(), results);
            end
            if (returns != pushes || pushes != n_flits)
            begin
               value_errors++;
               $display("Error credit_balance returns: expected %0d, actual %0d (flits %0d)",
                        n_flits, returns, pushes);
            end
            if (!stall_seen || file_bad)
            begin
               protocol_errors++;
               $display("the stall phase never ran or the pattern file was not read");
            end
            final_done = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* test/link_rx_patterns.txt */
1 1234 2
0 8000 0
0 9000 1
0 7fff 0
1 0001 3
0 00ff 0
1 ff01 0
0 0001 0
0 0002 0
0 0003 0
0 0004 0
1 0005 4
0 abcd 1
0 1111 0
1 2222 0
0 0100 0
0 0200 0
1 0300 0
0 1000 0
0 2000 0
0 3000 0
1 4000 0
0 aaaa 0
0 5555 0
0 0001 0
1 fffe 0
1 0000 1
0 ffff 0
0 ffff 0
0 ffff 0
0 ffff 0
0 ffff 0
1 ffff 2
0 0fff 3
0 f000 0
0 0011 1
1 0022 0
0 dead 0
0 beef 0
0 cafe 0
0 face 0
1 0bad 5

/* test/link_rx_tb.sv */
/* testbench for link_rx_top, reads test/link_rx_patterns.txt from the project root.
   the stall frame must be followed by at least 2^adr_width - 1 flits */
`default_nettype none

module link_rx_tb
   import link_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int adr_width = 3;
   localparam int depth = 1 << adr_width;
   localparam int stall_frame = 5;   // frame whose end flit gets held at the head
   localparam int hold_cycles = 12;
   localparam flit_t idle_flit = '{op_data, 16'h0000};

   logic          clk;
   logic          reset;
   logic          in_valid;
   flit_t         in_flit;
   logic          credit_return;
   logic          out_credit;
   logic          result_valid;
   frame_result_t result;
   logic          stalled;           // end flit stuck, grants off
   logic          run_done;
   bit            final_done;
   int            value_errors;
   int            protocol_errors;

   flit_t       pat_flit [$];
   int          pat_gap [$];
   int          stall_first = -1;    // index of the first flit of the stall frame
   int          limit_cycles = 0;
   logic [31:0] lfsr;
   logic        stall_on;
   int          driven = 0;          // counted when driven, not when sampled
   int          ends_driven = 0;
   int          grants_given = 0;
   int          returns = 0;
   int          results = 0;

   link_rx_top #(
      .adr_width (adr_width)
   ) uut (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (in_valid),
      .in_flit       (in_flit),
      .credit_return (credit_return),
      .out_credit    (out_credit),
      .result_valid  (result_valid),
      .result        (result)
   );

   link_rx_monitor #(
      .adr_width (adr_width)
   ) u_monitor (
      .clk             (clk),
      .reset           (reset),
      .in_valid        (in_valid),
      .credit_return   (credit_return),
      .out_credit      (out_credit),
      .result_valid    (result_valid),
      .result          (result),
      .stalled         (stalled),
      .run_done        (run_done),
      .value_errors    (value_errors),
      .protocol_errors (protocol_errors),
      .final_done      (final_done)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   function automatic int credits_left();
      return depth - driven + returns;
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         returns <= 0;
         results <= 0;
      end
      else
      begin
         if (credit_return)
            returns <= returns + 1;
         if (result_valid)
            results <= results + 1;
      end
   end

   task automatic load_patterns(output bit ok);
      int          fd;
      logic [31:0] op_v;
      logic [15:0] data_v;
      int          gap_v;
      int          frames;
      int          total;
      flit_t       f;
      frames = 0;
      total = 0;
      ok = 1'b0;
      fd = $fopen("test/link_rx_patterns.txt", "r");
      if (fd != 0)
      begin
         while ($fscanf(fd, "%h %h %d", op_v, data_v, gap_v) == 3)
         begin
            if (frames == stall_frame && stall_first < 0)
               stall_first = pat_flit.size();
            f.op   = flit_op_t'(op_v[0]);
            f.data = data_v;
            pat_flit.push_back(f);
            pat_gap.push_back(gap_v);
            if (op_v[0])
               frames++;
            total += 1 + gap_v;
         end
         $fclose(fd);
         limit_cycles = total * 20 + 500;
         ok = (pat_flit.size() > 0);
      end
   endtask

   // one cycle of input, downstream grant only for frames already sent
   task automatic drive_cycle(input logic valid, input flit_t flit);
      logic grant;
      @(negedge clk);
      in_valid = valid;
      in_flit  = flit;
      if (valid)
      begin
         driven++;
         if (flit.op == op_end)
            ends_driven++;
      end
      grant = 1'b0;
      if (!stall_on && grants_given < ends_driven)
      begin
         lfsr  = lfsr_step(lfsr);
         grant = lfsr[0];
      end
      out_credit = grant;
      if (grant)
         grants_given++;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic release_stall();
      repeat (hold_cycles) drive_cycle(1'b0, idle_flit);
      stalled  = 1'b0;
      stall_on = 1'b0;   // grants resume from the next cycle
   endtask

   task automatic run_stimulus();
      for (int i = 0; i < pat_flit.size(); i++)
      begin
         if (i == stall_first)
         begin
            // empty FIFO and no credit held before the stall
            while (results != ends_driven || returns != driven)
               drive_cycle(1'b0, idle_flit);
            stall_on = 1'b1;
         end
         while (credits_left() == 0)
         begin
            if (stalled)
               release_stall();
            else
               drive_cycle(1'b0, idle_flit);
         end
         drive_cycle(1'b1, pat_flit[i]);
         repeat (pat_gap[i]) drive_cycle(1'b0, idle_flit);
         if (stall_on && !stalled && pat_flit[i].op == op_end)
         begin
            drive_cycle(1'b0, idle_flit);
            while (returns != driven - 1)   // only the end flit left inside
               drive_cycle(1'b0, idle_flit);
            stalled = 1'b1;
         end
      end
      if (stalled)
         release_stall();
   endtask

   task automatic drain_outputs();
      while (results != ends_driven || returns != driven)
         drive_cycle(1'b0, idle_flit);
      repeat (4) drive_cycle(1'b0, idle_flit);
      run_done = 1'b1;
      wait (final_done);
   endtask

   task automatic print_summary(input bit aborted);
      $display("errors: %0d value, %0d protocol%s", value_errors, protocol_errors,
               aborted ? ", run aborted" : "");
      if (value_errors == 0 && protocol_errors == 0 && !aborted)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
   endtask

   initial
   begin
      bit ok;
      reset      = 1'b1;
      in_valid   = 1'b0;
      in_flit    = idle_flit;
      out_credit = 1'b0;
      stalled    = 1'b0;
      run_done   = 1'b0;
      stall_on   = 1'b0;
      lfsr       = 32'h9972;
      load_patterns(ok);
      if (!ok)
      begin
         $display("could not read test/link_rx_patterns.txt");
         print_summary(1'b1);
      end
      else
      begin
         apply_reset();
         run_stimulus();
         drain_outputs();
         print_summary(1'b0);
      end
      $finish;
   end

   // watchdog, scaled to the pattern length
   initial
   begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: the run did not end within %0d cycles", limit_cycles);
      print_summary(1'b1);
      $finish;
   end

endmodule

`default_nettype wire
